//--- Makefile
# Verilator build and run of the matrix divider testbench

TOP := matrix_divider_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f compile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
+incdir+rtl
rtl/matrix_divider_pkg.sv
rtl/operand_capture.sv
rtl/integer_divider_core.sv
rtl/matrix_divider_ctrl.sv
rtl/matrix_divider_top.sv
dv/matrix_divider_checker.sv
dv/matrix_divider_tb.sv

//--- dv/matrix_divider_checker.sv
/*
  Protocol assertions on the matrix divider outputs.
  Bound to the top level of the design.
*/

`timescale 1ns/1ns
`default_nettype none

module matrix_divider_checker (
  input wire logic CLK,
  input wire logic RST,
  input wire logic start,
  input wire logic out_enable,
  input wire logic row_end,
  input wire logic ready
);

  // Set by the first start after reset
  logic started;

  // Failed assertion count read by the testbench
  int unsigned assert_fails = 0;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      started <= 1'b0;
    end else if (start) begin
      started <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Pulse width
  ////////////////////////////////////////

  a_out_enable_pulse: assert property (@(posedge CLK) disable iff (RST)
    out_enable |=> !out_enable)
    else begin
      $error("out_enable held longer than one cycle");
      assert_fails++;
    end

  a_row_end_pulse: assert property (@(posedge CLK) disable iff (RST)
    row_end |=> !row_end)
    else begin
      $error("row_end held longer than one cycle");
      assert_fails++;
    end

  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else begin
      $error("ready held longer than one cycle");
      assert_fails++;
    end

  ////////////////////////////////////////
  // Flag relations
  ////////////////////////////////////////

  // Last element is also a last column
  a_ready_flags: assert property (@(posedge CLK) disable iff (RST)
    ready |-> (row_end && out_enable))
    else begin
      $error("ready without row_end and out_enable");
      assert_fails++;
    end

  // Quiet between reset and the first start
  a_quiet_before_start: assert property (@(posedge CLK) disable iff (RST)
    !started |-> !(out_enable || row_end || ready))
    else begin
      $error("output pulse before the first start");
      assert_fails++;
    end

endmodule

bind matrix_divider_top matrix_divider_checker u_checker (
  .CLK        (CLK),
  .RST        (RST),
  .start      (start),
  .out_enable (out_enable),
  .row_end    (row_end),
  .ready      (ready)
);

`default_nettype wire

//--- dv/matrix_divider_tb.sv
/*
  Table-driven testbench for the matrix divider top level.
  Each table entry runs one matrix; results are checked against a scoreboard.
*/

`timescale 1ns/1ns
`default_nettype none

`include "matrix_divider_defines.svh"

module matrix_divider_tb
  import matrix_divider_pkg::*;
;

  localparam int W           = `MD_DATA_WIDTH;
  localparam int MAX_TESTS   = 16;
  localparam logic [31:0] LFSR_SEED = 32'h718f71d1;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  typedef enum {MODE_RANDOM, MODE_ZERO_DIV, MODE_SMALL_DIVIDEND, MODE_MAX} operand_mode_t;
  typedef enum {GAP_BOTH, GAP_B_FIRST, GAP_A_FIRST} gap_t;

  typedef struct {
    string         name;
    int            rows;
    int            cols;
    operand_mode_t mode;
    gap_t          gap;
  } test_entry_t;

  // Scoreboard entry with result and flags
  typedef struct packed {
    div_result_t res;
    logic        row_end;
    logic        ready;
  } expect_t;

  // DUT ports
  logic         CLK;
  logic         RST;
  logic         start;
  matrix_size_t size;
  logic         a_enable;
  dividend_t    a_data;
  logic         b_enable;
  divisor_t     b_data;
  logic         out_enable;
  div_result_t  out;
  logic         row_end;
  logic         ready;

  test_entry_t tests[MAX_TESTS];
  int          num_tests;
  expect_t     expected_q[$];
  string       cur_name;
  logic [31:0] lfsr_state;
  int          results_seen;
  int          value_errors;
  int          flag_errors;
  int          other_errors;
  int          assert_errors;
  int          cycle_count;
  int          cycle_limit;

  matrix_divider_top u_matrix_divider_top (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size       (size),
    .a_enable   (a_enable),
    .a_data     (a_data),
    .b_enable   (b_enable),
    .b_data     (b_data),
    .out_enable (out_enable),
    .out        (out),
    .row_end    (row_end),
    .ready      (ready)
  );

  always #4 CLK = ~CLK;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Zero divisor gives all ones and the dividend back
  function automatic div_result_t expected_div(input dividend_t a, input divisor_t b);
    div_result_t r;
    if (b == '0) begin
      r.quotient  = '1;
      r.remainder = a;
    end else begin
      r.quotient  = a / b;
      r.remainder = a % b;
    end
    return r;
  endfunction

  task automatic make_operands(input operand_mode_t mode, input int idx,
                               output dividend_t a, output divisor_t b);
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] sh;
    ra = rand_bits(W);
    rb = rand_bits(W);
    case (mode)
      MODE_ZERO_DIV: begin
        a = ra[W-1:0];
        b = '0;
      end
      MODE_SMALL_DIVIDEND: begin
        // Top bit splits the two ranges
        a = {1'b0, ra[W-2:0]};
        b = {1'b1, rb[W-2:0]};
      end
      MODE_MAX: begin
        a = '1;
        case (idx % 4)
          0: b = '1;
          1: b = divisor_t'(1);
          2: b = {1'b1, {(W-1){1'b0}}};
          default: b = {{(W-1){1'b1}}, 1'b0};
        endcase
      end
      default: begin
        // Random shift spreads the quotient range
        sh = rand_bits(4);
        a = ra[W-1:0];
        b = rb[W-1:0] >> sh[3:0];
      end
    endcase
  endtask

  // Drives both strobes per gap pattern between falling edges
  task automatic drive_pair(input dividend_t a, input divisor_t b, input gap_t gap);
    int a_delay;
    int b_delay;
    int last;
    case (gap)
      GAP_B_FIRST: begin
        a_delay = 2;
        b_delay = 0;
      end
      GAP_A_FIRST: begin
        a_delay = 0;
        b_delay = 4;
      end
      default: begin
        a_delay = 0;
        b_delay = 0;
      end
    endcase
    last   = (a_delay > b_delay) ? a_delay : b_delay;
    a_data = a;
    b_data = b;
    for (int t = 0; t <= last; t++) begin
      @(negedge CLK);
      a_enable = (t == a_delay);
      b_enable = (t == b_delay);
    end
    @(negedge CLK);
    a_enable = 1'b0;
    b_enable = 1'b0;
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_result(input string what, input div_result_t exp, input div_result_t act);
    if (exp !== act) begin
      value_errors++;
      $display("[FAIL] %s %s expected q=%h r=%h actual q=%h r=%h", cur_name, what,
               exp.quotient, exp.remainder, act.quotient, act.remainder);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      flag_errors++;
      $display("[FAIL] %s %s expected %b actual %b", cur_name, what, exp, act);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge CLK) begin : monitor
    expect_t e;
    if (!RST) begin
      if (out_enable) begin
        if (expected_q.size() == 0) begin
          other_errors++;
          $display("Unexpected out_enable pulse in %s, no result was pending", cur_name);
        end else begin
          e = expected_q.pop_front();
          check_result("result", e.res, out);
          check_flag("row_end", e.row_end, row_end);
          check_flag("ready", e.ready, ready);
          results_seen++;
        end
      end else if (row_end || ready) begin
        other_errors++;
        $display("row_end or ready pulsed without out_enable in %s", cur_name);
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped producing results", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test table and sequence
  ////////////////////////////////////////

  task automatic add_test(input string name, input int rows, input int cols,
                          input operand_mode_t mode, input gap_t gap);
    tests[num_tests].name = name;
    tests[num_tests].rows = rows;
    tests[num_tests].cols = cols;
    tests[num_tests].mode = mode;
    tests[num_tests].gap  = gap;
    num_tests++;
  endtask

  // One matrix started on the current falling edge
  task automatic run_test(input int t);
    dividend_t a;
    divisor_t  b;
    expect_t   e;
    int        idx;
    cur_name     = tests[t].name;
    results_seen = 0;
    idx          = 0;
    size.rows    = tests[t].rows[`MD_INDEX_WIDTH-1:0];
    size.cols    = tests[t].cols[`MD_INDEX_WIDTH-1:0];
    start        = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    for (int r = 0; r < tests[t].rows; r++) begin
      for (int c = 0; c < tests[t].cols; c++) begin
        make_operands(tests[t].mode, idx, a, b);
        e.res     = expected_div(a, b);
        e.row_end = (c == tests[t].cols - 1);
        e.ready   = e.row_end && (r == tests[t].rows - 1);
        expected_q.push_back(e);
        drive_pair(a, b, tests[t].gap);
        while (!out_enable) begin
          @(negedge CLK);
        end
        idx++;
      end
    end
    // Next start goes out on this edge right after ready
    @(negedge CLK);
    if (results_seen != tests[t].rows * tests[t].cols) begin
      other_errors++;
      $display("[FAIL] %s result count expected %0d actual %0d", cur_name,
               tests[t].rows * tests[t].cols, results_seen);
    end
  endtask

  initial begin
    CLK           = 1'b0;
    RST           = 1'b1;
    start         = 1'b0;
    size          = '0;
    a_enable      = 1'b0;
    a_data        = '0;
    b_enable      = 1'b0;
    b_data        = '0;
    lfsr_state    = LFSR_SEED;
    num_tests     = 0;
    value_errors  = 0;
    flag_errors   = 0;
    other_errors  = 0;
    assert_errors = 0;
    cycle_count   = 0;

    add_test("rand_1x1", 1, 1, MODE_RANDOM, GAP_BOTH);
    add_test("rand_4x3", 4, 3, MODE_RANDOM, GAP_BOTH);
    add_test("rand_2x5_b_first", 2, 5, MODE_RANDOM, GAP_B_FIRST);
    add_test("rand_3x2_a_first", 3, 2, MODE_RANDOM, GAP_A_FIRST);
    add_test("zero_divisor", 2, 3, MODE_ZERO_DIV, GAP_BOTH);
    add_test("small_dividend", 3, 3, MODE_SMALL_DIVIDEND, GAP_B_FIRST);
    add_test("max_values", 2, 2, MODE_MAX, GAP_A_FIRST);
    add_test("rand_1x15", 1, 15, MODE_RANDOM, GAP_BOTH);

    // Per element budget plus reset and start overhead
    cycle_limit = 300;
    for (int t = 0; t < num_tests; t++) begin
      cycle_limit += tests[t].rows * tests[t].cols * (`MD_DIV_STEPS + 10);
    end

    repeat (16) @(negedge CLK);
    RST = 1'b0;
    // Idle stretch before the first start
    repeat (4) @(negedge CLK);

    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    repeat (4) @(negedge CLK);
    if (expected_q.size() != 0) begin
      other_errors++;
      $display("%0d expected results never came out", expected_q.size());
    end
    assert_errors = u_matrix_divider_top.u_checker.assert_fails;

    $display("Errors: result %0d, flag %0d, other %0d, assertion %0d", value_errors,
             flag_errors, other_errors, assert_errors);
    if (value_errors + flag_errors + other_errors + assert_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/integer_divider_core.sv
/*
  Unsigned restoring divider, one quotient bit per cycle.
  Pulse start with the operands; done follows `MD_DIV_STEPS + 1 cycles later.
*/

`timescale 1ns/1ns
`default_nettype none

`include "matrix_divider_defines.svh"

module integer_divider_core
  import matrix_divider_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  dividend_t   dividend,
  input  divisor_t    divisor,
  output logic        busy,
  output logic        done,
  output div_result_t result
);

  localparam int unsigned W        = `MD_DATA_WIDTH;
  localparam int unsigned CNT_W    = $clog2(`MD_DIV_STEPS);
  localparam int unsigned LAST_STEP = `MD_DIV_STEPS - 1;

  ////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////

  // Partial remainder
  logic [W-1:0]     rem_q;
  // Dividend shifts out on top, quotient bits shift in below
  logic [W-1:0]     quo_q;
  logic [W-1:0]     dsr_q;
  logic [CNT_W-1:0] step_cnt;

  // One restoring step
  logic [W:0] trial;
  logic [W:0] diff;
  logic       fits;

  assign trial = {rem_q, quo_q[W-1]};
  assign diff  = trial - {1'b0, dsr_q};
  // Zero divisor always fits, hence all-ones quotient
  assign fits  = (trial >= {1'b0, dsr_q});

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      step_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy && start) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        // Last bit retired this cycle
        if (step_cnt == LAST_STEP[CNT_W-1:0]) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Load on start, then shift-subtract while busy
  always_ff @(posedge CLK) begin
    if (!busy && start) begin
      rem_q <= '0;
      quo_q <= dividend;
      dsr_q <= divisor;
    end else if (busy) begin
      rem_q <= fits ? diff[W-1:0] : trial[W-1:0];
      quo_q <= {quo_q[W-2:0], fits};
    end
  end

  // Valid while done is high
  assign result.quotient  = quo_q;
  assign result.remainder = rem_q;

endmodule

`default_nettype wire

//--- rtl/matrix_divider_ctrl.sv
/*
  Row and column sequencer of the matrix divider.
  Pairs captured operands, launches the core, registers each result
  and flags row ends and the last element.
*/

`timescale 1ns/1ns
`default_nettype none

`include "matrix_divider_defines.svh"

module matrix_divider_ctrl
  import matrix_divider_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         start,
  input  matrix_size_t size,
  input  logic         a_full,
  input  logic         b_full,
  input  logic         core_done,
  input  div_result_t  core_result,
  output logic         take,
  output logic         core_start,
  output logic         out_enable,
  output logic         row_end,
  output logic         ready,
  output div_result_t  out
);

  ////////////////////////////////////////
  // State and indices
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DIV,
    ST_EMIT
  } ctrl_state_t;

  ctrl_state_t state;

  logic [`MD_INDEX_WIDTH-1:0] row_idx;
  logic [`MD_INDEX_WIDTH-1:0] col_idx;

  // Size is stable from start until ready
  logic [`MD_INDEX_WIDTH-1:0] last_row;
  logic [`MD_INDEX_WIDTH-1:0] last_col;
  logic                       at_last_col;
  logic                       at_last_elem;
  logic                       pair_ready;

  assign last_row     = size.rows - 1'b1;
  assign last_col     = size.cols - 1'b1;
  assign at_last_col  = (col_idx == last_col);
  assign at_last_elem = at_last_col && (row_idx == last_row);
  // Both operands waiting in their capture units
  assign pair_ready   = a_full && b_full;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ST_IDLE;
      row_idx    <= '0;
      col_idx    <= '0;
      take       <= 1'b0;
      core_start <= 1'b0;
      out_enable <= 1'b0;
      row_end    <= 1'b0;
      ready      <= 1'b0;
    end else begin
      // Every strobe is a single-cycle pulse
      take       <= 1'b0;
      core_start <= 1'b0;
      out_enable <= 1'b0;
      row_end    <= 1'b0;
      ready      <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (start) begin
            row_idx <= '0;
            col_idx <= '0;
            state   <= ST_WAIT;
          end
        end

        ST_WAIT: begin
          // Take and launch together
          if (pair_ready) begin
            take       <= 1'b1;
            core_start <= 1'b1;
            state      <= ST_DIV;
          end
        end

        ST_DIV: begin
          if (core_done) begin
            out_enable <= 1'b1;
            row_end    <= at_last_col;
            ready      <= at_last_elem;

            // Row-major stepping
            if (at_last_col) begin
              col_idx <= '0;
              row_idx <= at_last_elem ? '0 : row_idx + 1'b1;
            end else begin
              col_idx <= col_idx + 1'b1;
            end
            state <= ST_EMIT;
          end
        end

        ST_EMIT: begin
          // Result is on the outputs this cycle
          if (ready) begin
            state <= ST_IDLE;
          end else if (pair_ready) begin
            // Next pair already captured, launch without a wait cycle
            take       <= 1'b1;
            core_start <= 1'b1;
            state      <= ST_DIV;
          end else begin
            state <= ST_WAIT;
          end
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  // Payload only, qualified by out_enable
  always_ff @(posedge CLK) begin
    if (state == ST_DIV && core_done) begin
      out <= core_result;
    end
  end

endmodule

`default_nettype wire

//--- rtl/matrix_divider_defines.svh
/*
  Width and iteration macros for the matrix divider.
  Include wherever a width or the divider step count is needed.
*/

`ifndef MATRIX_DIVIDER_DEFINES_SVH
`define MATRIX_DIVIDER_DEFINES_SVH

// Dividend, divisor, quotient and remainder width
`define MD_DATA_WIDTH 16

// Row and column count width, up to 15 by 15
`define MD_INDEX_WIDTH 4

// One quotient bit per iteration
`define MD_DIV_STEPS `MD_DATA_WIDTH

`endif

//--- rtl/matrix_divider_pkg.sv
/*
  Shared types of the matrix divider: operands, matrix size and result.
  Modules import this package in their header.
*/

`default_nettype none

`include "matrix_divider_defines.svh"

package matrix_divider_pkg;

  ////////////////////////////////////////
  // Operand elements
  ////////////////////////////////////////

  // Element on the A stream
  typedef logic [`MD_DATA_WIDTH-1:0] dividend_t;

  // Element on the B stream
  typedef logic [`MD_DATA_WIDTH-1:0] divisor_t;

  ////////////////////////////////////////
  // Matrix shape and result
  ////////////////////////////////////////

  // Both counts are at least one
  typedef struct packed {
    logic [`MD_INDEX_WIDTH-1:0] rows;
    logic [`MD_INDEX_WIDTH-1:0] cols;
  } matrix_size_t;

  // Quotient in the upper half, remainder in the lower half
  typedef struct packed {
    logic [`MD_DATA_WIDTH-1:0] quotient;
    logic [`MD_DATA_WIDTH-1:0] remainder;
  } div_result_t;

endpackage

`default_nettype wire

//--- rtl/matrix_divider_top.sv
/*
  Element-wise matrix divider top level.
  Pulse start with size, then stream A and B elements in row-major order.
  Results come back as out_enable pulses with row_end and ready flags.
*/

`timescale 1ns/1ns
`default_nettype none

module matrix_divider_top
  import matrix_divider_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         start,
  input  matrix_size_t size,
  input  logic         a_enable,
  input  dividend_t    a_data,
  input  logic         b_enable,
  input  divisor_t     b_data,
  output logic         out_enable,
  output div_result_t  out,
  output logic         row_end,
  output logic         ready
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  // Capture units
  logic        a_full;
  logic        b_full;
  dividend_t   a_value;
  divisor_t    b_value;
  logic        take;

  // Divider core
  logic        core_start;
  logic        core_done;
  div_result_t core_result;

  ////////////////////////////////////////
  // Operand capture, A and B
  ////////////////////////////////////////

  operand_capture #(
    .payload_t (dividend_t)
  ) u_a_capture (
    .CLK    (CLK),
    .RST    (RST),
    .enable (a_enable),
    .data   (a_data),
    .take   (take),
    .full   (a_full),
    .value  (a_value)
  );

  operand_capture #(
    .payload_t (divisor_t)
  ) u_b_capture (
    .CLK    (CLK),
    .RST    (RST),
    .enable (b_enable),
    .data   (b_data),
    .take   (take),
    .full   (b_full),
    .value  (b_value)
  );

  // Sequencer
  matrix_divider_ctrl u_ctrl (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size        (size),
    .a_full      (a_full),
    .b_full      (b_full),
    .core_done   (core_done),
    .core_result (core_result),
    .take        (take),
    .core_start  (core_start),
    .out_enable  (out_enable),
    .row_end     (row_end),
    .ready       (ready),
    .out         (out)
  );

  // Shared divider working one element at a time
  integer_divider_core u_core (
    .CLK      (CLK),
    .RST      (RST),
    .start    (core_start),
    .dividend (a_value),
    .divisor  (b_value),
    .busy     (),
    .done     (core_done),
    .result   (core_result)
  );

endmodule

`default_nettype wire

//--- rtl/operand_capture.sv
/*
  One-deep holding register for an operand stream.
  Captures a value on its strobe, holds it with full set, and frees it on take.
*/

`timescale 1ns/1ns
`default_nettype none

module operand_capture
  import matrix_divider_pkg::*;
#(
  parameter type payload_t = dividend_t
) (
  input  logic     CLK,
  input  logic     RST,
  input  logic     enable,
  input  payload_t data,
  input  logic     take,
  output logic     full,
  output payload_t value
);

  // Strobe is accepted only while empty
  logic accept;

  assign accept = enable && !full;

  ////////////////////////////////////////
  // Full flag
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      full <= 1'b0;
    end else if (take) begin
      // Consumed by the controller
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end
  end

  // Held operand, payload only
  always_ff @(posedge CLK) begin
    if (accept) begin
      value <= data;
    end
  end

endmodule

`default_nettype wire
